//--- all.f
+incdir+.
cpu_pkg.sv
decoded_if.sv
register_file.sv
fetch_decode.sv
issue_register.sv
execute_writeback.sv
cpu.sv
cpu_checker.sv
tb_cpu.sv

//--- run.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_cpu \
    --Mdir obj_dir -o tb_cpu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_cpu_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

//--- tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    localparam int CLK_PERIOD       = 40;
    localparam int RESET_CYCLES     = 3;
    localparam int MEM_AW           = 6;
    localparam int DIRECTED_LEN     = 24;
    localparam int RANDOM_LEN       = 40;
    localparam int RANDOM_PROGRAMS  = 4;
    localparam int POST_HALT_CYCLES = 8;
    localparam int TOTAL_LEN        = DIRECTED_LEN + RANDOM_PROGRAMS * RANDOM_LEN;
    // Four cycles per word plus reset and settling per program
    localparam int TIMEOUT_CYCLES   = TOTAL_LEN * 4
        + (RANDOM_PROGRAMS + 1) * (RESET_CYCLES + POST_HALT_CYCLES + 2) + 50;
    localparam logic [31:0] SEED    = 32'd83;

    logic        clk;
    logic        reset_n;
    logic        read_m1;
    word_t       address1;
    word_t       data1;
    word_t       num_inst;
    word_t       output_port;
    logic        is_halted;
    int          value_errors;
    int          protocol_errors;
    word_t       prog_mem [2**MEM_AW];
    logic [31:0] rng;

    cpu i_dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .read_m1     (read_m1),
        .address1    (address1),
        .data1       (data1),
        .num_inst    (num_inst),
        .output_port (output_port),
        .is_halted   (is_halted)
    );

    cpu_checker i_checker (
        .clk             (clk),
        .reset_n         (reset_n),
        .read_m1         (read_m1),
        .address1        (address1),
        .data1           (data1),
        .num_inst        (num_inst),
        .output_port     (output_port),
        .is_halted       (is_halted),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Instruction memory, one cycle of read latency
    always @(posedge clk) begin
        if (read_m1) begin
            data1 <= prog_mem[address1[MEM_AW-1:0]];
        end
    end

    ////////////////////////////////////////////////////////////
    // Program generation

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t encode_r(alu_func_e fn, reg_addr_t rs, reg_addr_t rt,
                                       reg_addr_t rd);
        return {OP_RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic word_t encode_i(opcode_e op, reg_addr_t rs, reg_addr_t rt,
                                       logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t random_instruction(logic [31:0] r);
        logic [3:0] kind;
        kind = r[3:0];
        case (kind)
            4'd8:  return encode_i(OP_ADI, r[5:4], r[7:6], r[17:10]);
            4'd9:  return encode_i(OP_ORI, r[5:4], r[7:6], r[17:10]);
            4'd10: return encode_i(OP_LHI, r[5:4], r[7:6], r[17:10]);
            4'd11, 4'd12, 4'd13, 4'd14, 4'd15: return encode_r(FN_WWD, r[5:4], 2'd0, 2'd0);
            default: return encode_r(alu_func_e'({2'b00, kind}), r[5:4], r[7:6], r[9:8]);
        endcase
    endfunction

    task automatic fill_memory();
        for (int i = 0; i < 2**MEM_AW; i++) begin
            // Filler differs at every address
            prog_mem[i] = encode_i(OP_ADI, i[1:0], i[3:2], i[7:0] ^ 8'hA5);
        end
    endtask

    task automatic load_directed();
        fill_memory();
        prog_mem[0]  = encode_i(OP_LHI, 2'd0, 2'd1, 8'h12);
        prog_mem[1]  = encode_i(OP_ORI, 2'd1, 2'd1, 8'h34);
        prog_mem[2]  = encode_r(FN_WWD, 2'd1, 2'd0, 2'd0);
        prog_mem[3]  = encode_i(OP_ADI, 2'd0, 2'd2, 8'hFD);
        prog_mem[4]  = encode_r(FN_WWD, 2'd2, 2'd0, 2'd0);
        prog_mem[5]  = encode_r(FN_ADD, 2'd1, 2'd2, 2'd3);
        prog_mem[6]  = encode_r(FN_WWD, 2'd3, 2'd0, 2'd0);
        prog_mem[7]  = encode_r(FN_SUB, 2'd1, 2'd2, 2'd3);
        prog_mem[8]  = encode_r(FN_WWD, 2'd3, 2'd0, 2'd0);
        prog_mem[9]  = encode_r(FN_AND, 2'd1, 2'd2, 2'd3);
        prog_mem[10] = encode_r(FN_WWD, 2'd3, 2'd0, 2'd0);
        prog_mem[11] = encode_r(FN_ORR, 2'd3, 2'd2, 2'd3);
        prog_mem[12] = encode_r(FN_WWD, 2'd3, 2'd0, 2'd0);
        prog_mem[13] = encode_r(FN_NOT, 2'd1, 2'd0, 2'd3);
        prog_mem[14] = encode_r(FN_WWD, 2'd3, 2'd0, 2'd0);
        prog_mem[15] = encode_r(FN_TCP, 2'd2, 2'd0, 2'd3);
        prog_mem[16] = encode_r(FN_WWD, 2'd3, 2'd0, 2'd0);
        prog_mem[17] = encode_r(FN_SHL, 2'd1, 2'd0, 2'd3);
        prog_mem[18] = encode_r(FN_WWD, 2'd3, 2'd0, 2'd0);
        prog_mem[19] = encode_r(FN_SHR, 2'd2, 2'd0, 2'd0);
        prog_mem[20] = encode_r(FN_WWD, 2'd0, 2'd0, 2'd0);
        prog_mem[21] = encode_r(FN_HLT, 2'd0, 2'd0, 2'd0);
        // Must never retire
        prog_mem[22] = encode_i(OP_ADI, 2'd1, 2'd1, 8'h01);
        prog_mem[23] = encode_r(FN_WWD, 2'd1, 2'd0, 2'd0);
    endtask

    task automatic load_random();
        fill_memory();
        for (int i = 0; i < RANDOM_LEN - 1; i++) begin
            rng = xorshift32(rng);
            prog_mem[i] = random_instruction(rng);
        end
        prog_mem[RANDOM_LEN - 1] = encode_r(FN_HLT, 2'd0, 2'd0, 2'd0);
    endtask

    ////////////////////////////////////////////////////////////
    // Sequencing

    task automatic apply_reset();
        @(posedge clk);
        reset_n <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b0;
    endtask

    task automatic run_program(input string label);
        apply_reset();
        while (is_halted !== 1'b1) begin
            @(posedge clk);
        end
        repeat (POST_HALT_CYCLES) @(posedge clk);
        $display("%s program halted with num_inst %0d", label, num_inst);
    endtask

    initial begin
        reset_n = 1'b1;
        data1   = '0;
        rng     = SEED;
        load_directed();
        run_program("Directed");
        for (int p = 0; p < RANDOM_PROGRAMS; p++) begin
            load_random();
            run_program("Random");
        end
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the programs did not all halt within %0d cycles", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- cpu_checker.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_checker (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           read_m1,
    input  cpu_pkg::word_t address1,
    input  cpu_pkg::word_t data1,
    input  cpu_pkg::word_t num_inst,
    input  cpu_pkg::word_t output_port,
    input  logic           is_halted,
    output int             value_errors,
    output int             protocol_errors
);
    import cpu_pkg::*;

    word_t model_regs [`REG_COUNT];
    word_t fetched [$];
    word_t exp_out;
    word_t exp_addr;
    word_t retired;
    word_t recorded;
    logic  exp_halted;
    logic  req_q;
    logic  recording;
    logic  first_cycle;
    logic  prev_halted;
    int    value_count = 0;
    int    protocol_count = 0;

    assign value_errors    = value_count;
    assign protocol_errors = protocol_count;

    ////////////////////////////////////////////////////////////
    // Reference model

    function automatic word_t reference_result(word_t instr, word_t rs_val, word_t rt_val);
        logic [`OPCODE_HI-`OPCODE_LO:0] op;
        logic [`FUNC_HI-`FUNC_LO:0]     fn;
        logic [`IMM_W-1:0]              imm;
        op  = instr[`OPCODE_HI:`OPCODE_LO];
        fn  = instr[`FUNC_HI:`FUNC_LO];
        imm = instr[`IMM_W-1:0];
        case (op)
            OP_ADI: return rs_val + word_t'($signed(imm));
            OP_ORI: return rs_val | word_t'(imm);
            OP_LHI: return word_t'(imm) << (`WORD_SIZE - `IMM_W);
            OP_RTYPE: begin
                case (fn)
                    FN_ADD: return rs_val + rt_val;
                    FN_SUB: return rs_val - rt_val;
                    FN_AND: return rs_val & rt_val;
                    FN_ORR: return rs_val | rt_val;
                    FN_NOT: return ~rs_val;
                    FN_TCP: return -rs_val;
                    FN_SHL: return rs_val << 1;
                    FN_SHR: return $signed(rs_val) >>> 1;
                    // WWD sends rs out unchanged
                    default: return rs_val;
                endcase
            end
            default: return '0;
        endcase
    endfunction

    task automatic retire_word(input word_t instr);
        word_t                          result;
        reg_addr_t                      rt;
        reg_addr_t                      rd;
        logic [`OPCODE_HI-`OPCODE_LO:0] op;
        logic [`FUNC_HI-`FUNC_LO:0]     fn;
        rt     = instr[`RT_HI:`RT_LO];
        rd     = instr[`RD_HI:`RD_LO];
        op     = instr[`OPCODE_HI:`OPCODE_LO];
        fn     = instr[`FUNC_HI:`FUNC_LO];
        result = reference_result(instr, model_regs[instr[`RS_HI:`RS_LO]], model_regs[rt]);
        if (op == OP_RTYPE) begin
            if (fn == FN_WWD) begin
                exp_out = result;
            end else if (fn == FN_HLT) begin
                exp_halted = 1'b1;
            end else if (fn <= FN_SHR) begin
                model_regs[rd] = result;
            end
        end else if (op == OP_ADI || op == OP_ORI || op == OP_LHI) begin
            model_regs[rt] = result;
        end
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            value_count++;
            $display("ERROR at %0t: %s expected %h, actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        protocol_count++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    ////////////////////////////////////////////////////////////
    // Port monitor

    always @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                model_regs[i] = '0;
            end
            fetched.delete();
            exp_out     = '0;
            exp_addr    = '0;
            retired     = '0;
            recorded    = '0;
            exp_halted  = 1'b0;
            req_q       = 1'b0;
            recording   = 1'b1;
            first_cycle = 1'b1;
            prev_halted = 1'b0;
            if (read_m1) begin
                report_failure("instruction request while reset is held");
            end
        end else begin
            if (first_cycle && !read_m1) begin
                report_failure("no instruction request in the first cycle after reset");
            end
            first_cycle = 1'b0;
            // data1 answers the request of the previous cycle
            if (req_q && recording) begin
                fetched.push_back(data1);
                recorded = recorded + word_t'(1);
                if (data1[`OPCODE_HI:`OPCODE_LO] == OP_RTYPE &&
                    data1[`FUNC_HI:`FUNC_LO] == FN_HLT) begin
                    recording = 1'b0;
                end
            end
            req_q = read_m1;
            if (read_m1) begin
                if (exp_halted) begin
                    report_failure("instruction request after HLT retired");
                end
                check_value("address1", exp_addr, address1);
                exp_addr = exp_addr + word_t'(1);
            end
            if (num_inst === retired + word_t'(1)) begin
                if (exp_halted) begin
                    report_failure("instruction retired after HLT");
                end else if (fetched.size() == 0) begin
                    report_failure("instruction retired that was never fetched");
                end else begin
                    retire_word(fetched.pop_front());
                    retired = retired + word_t'(1);
                end
            end
            // Count at the halt covers every word up to HLT
            if (is_halted === 1'b1 && !prev_halted) begin
                check_value("num_inst", recorded, num_inst);
                if (fetched.size() != 0) begin
                    report_failure("fetched words left over when the CPU halted");
                end
            end
            prev_halted = (is_halted === 1'b1);
            check_value("num_inst", retired, num_inst);
            check_value("output_port", exp_out, output_port);
            check_value("is_halted", {{(`WORD_SIZE-1){1'b0}}, exp_halted},
                        {{(`WORD_SIZE-1){1'b0}}, is_halted});
        end
    end

endmodule

//--- cpu.sv
`timescale 1ns/1ps

module cpu (
    input  logic           clk,
    input  logic           reset_n,
    output logic           read_m1,
    output cpu_pkg::word_t address1,
    input  cpu_pkg::word_t data1,
    output cpu_pkg::word_t num_inst,
    output cpu_pkg::word_t output_port,
    output logic           is_halted
);
    import cpu_pkg::*;

    reg_addr_t read_reg_a;
    reg_addr_t read_reg_b;
    word_t     read_data_a;
    word_t     read_data_b;
    logic      wb_en;
    reg_addr_t wb_reg;
    word_t     wb_data;

    decoded_if dec_to_issue ();
    decoded_if issue_to_exec ();

    ////////////////////////////////////////////////////////////
    // Pipeline

    fetch_decode i_fetch_decode (
        .clk         (clk),
        .reset_n     (reset_n),
        .read_m1     (read_m1),
        .address1    (address1),
        .data1       (data1),
        .dec         (dec_to_issue.producer),
        .read_reg_a  (read_reg_a),
        .read_reg_b  (read_reg_b),
        .read_data_a (read_data_a),
        .read_data_b (read_data_b)
    );

    issue_register i_issue_register (
        .clk     (clk),
        .reset_n (reset_n),
        .dec     (dec_to_issue.buffer_in),
        .iss     (issue_to_exec.buffer_out)
    );

    execute_writeback i_execute_writeback (
        .clk         (clk),
        .reset_n     (reset_n),
        .iss         (issue_to_exec.consumer),
        .wb_en       (wb_en),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .num_inst    (num_inst),
        .output_port (output_port),
        .is_halted   (is_halted)
    );

    register_file i_register_file (
        .clk         (clk),
        .reset_n     (reset_n),
        .read_reg_a  (read_reg_a),
        .read_reg_b  (read_reg_b),
        .read_data_a (read_data_a),
        .read_data_b (read_data_b),
        .wb_en       (wb_en),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data)
    );

endmodule

//--- execute_writeback.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module execute_writeback (
    input  logic               clk,
    input  logic               reset_n,
    decoded_if.consumer        iss,
    output logic               wb_en,
    output cpu_pkg::reg_addr_t wb_reg,
    output cpu_pkg::word_t     wb_data,
    output cpu_pkg::word_t     num_inst,
    output cpu_pkg::word_t     output_port,
    output logic               is_halted
);
    import cpu_pkg::*;

    word_t alu_a;
    word_t alu_b;
    word_t alu_result;
    word_t num_inst_q;
    word_t output_q;
    logic  halt_q;

    ////////////////////////////////////////////////////////////
    // ALU

    assign alu_a = iss.instr.operand_a;
    assign alu_b = iss.instr.use_imm ? iss.instr.imm_value : iss.instr.operand_b;

    always_comb begin
        case (iss.instr.func)
            FN_ADD: alu_result = alu_a + alu_b;
            FN_SUB: alu_result = alu_a - alu_b;
            FN_AND: alu_result = alu_a & alu_b;
            FN_ORR: alu_result = alu_a | alu_b;
            FN_NOT: alu_result = ~alu_a;
            FN_TCP: alu_result = ~alu_a + word_t'(1);
            FN_SHL: alu_result = {alu_a[`WORD_SIZE-2:0], 1'b0};
            // Arithmetic shift
            FN_SHR: alu_result = {alu_a[`WORD_SIZE-1], alu_a[`WORD_SIZE-1:1]};
            FN_LHI: alu_result = alu_b;
            FN_WWD, FN_HLT: alu_result = '0;
            default: alu_result = '0;
        endcase
    end

    assign wb_en   = iss.valid && iss.instr.writes_reg;
    assign wb_reg  = iss.instr.dest;
    assign wb_data = alu_result;

    ////////////////////////////////////////////////////////////
    // Retire

    always_ff @(posedge clk) begin
        if (reset_n) begin
            num_inst_q <= '0;
            output_q   <= '0;
            halt_q     <= 1'b0;
        end else if (iss.valid) begin
            num_inst_q <= num_inst_q + word_t'(1);
            if (iss.instr.func == FN_WWD) begin
                output_q <= alu_a;
            end
            if (iss.instr.func == FN_HLT) begin
                halt_q <= 1'b1;
            end
        end
    end

    assign num_inst      = num_inst_q;
    assign output_port   = output_q;
    assign is_halted     = halt_q;
    assign iss.halt_seen = halt_q;

    // Nothing retires once halted
    property p_count_frozen;
        @(posedge clk) disable iff (reset_n)
            halt_q |=> $stable(num_inst_q);
    endproperty
    a_count_frozen: assert property (p_count_frozen)
        else $error("num_inst changed after halt");

endmodule

//--- issue_register.sv
`timescale 1ns/1ps

module issue_register (
    input logic           clk,
    input logic           reset_n,
    decoded_if.buffer_in  dec,
    decoded_if.buffer_out iss
);
    import cpu_pkg::*;

    logic     valid_q;
    decoded_t instr_q;

    ////////////////////////////////////////////////////////////
    // ID/EX register

    always_ff @(posedge clk) begin
        if (reset_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= dec.valid && !iss.halt_seen;
        end
    end

    // Operands and immediate ride along without reset
    always_ff @(posedge clk) begin
        instr_q <= dec.instr;
    end

    assign iss.valid = valid_q;
    assign iss.instr = instr_q;

    // Halt status goes back up to fetch
    assign dec.halt_seen = iss.halt_seen;

    // After halt, decode is empty and nothing more reaches execute
    property p_empty_after_halt;
        @(posedge clk) disable iff (reset_n)
            iss.halt_seen |-> (!dec.valid && !valid_q);
    endproperty
    a_empty_after_halt: assert property (p_empty_after_halt)
        else $error("instruction issued after halt");

endmodule

//--- fetch_decode.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module fetch_decode (
    input  logic               clk,
    input  logic               reset_n,
    output logic               read_m1,
    output cpu_pkg::word_t     address1,
    input  cpu_pkg::word_t     data1,
    decoded_if.producer        dec,
    output cpu_pkg::reg_addr_t read_reg_a,
    output cpu_pkg::reg_addr_t read_reg_b,
    input  cpu_pkg::word_t     read_data_a,
    input  cpu_pkg::word_t     read_data_b
);
    import cpu_pkg::*;

    word_t pc_q;
    logic  req_pending_q;
    logic  fetch_valid_q;
    word_t fetch_word_q;
    logic  halt_decoded_q;

    logic [`OPCODE_HI-`OPCODE_LO:0] opcode;
    logic [`FUNC_HI-`FUNC_LO:0]     func_raw;
    logic [`IMM_W-1:0]              imm_raw;
    logic                           hlt_now;
    logic                           stop_fetch;
    decoded_t                       instr;

    ////////////////////////////////////////////////////////////
    // Fetch

    assign opcode   = fetch_word_q[`OPCODE_HI:`OPCODE_LO];
    assign func_raw = fetch_word_q[`FUNC_HI:`FUNC_LO];
    assign imm_raw  = fetch_word_q[`IMM_W-1:0];

    assign hlt_now = fetch_valid_q && (opcode == OP_RTYPE) && (func_raw == FN_HLT);
    assign stop_fetch = halt_decoded_q || hlt_now || dec.halt_seen;

    // No request while reset is held
    assign read_m1  = !reset_n && !stop_fetch;
    assign address1 = pc_q;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc_q           <= '0;
            req_pending_q  <= 1'b0;
            fetch_valid_q  <= 1'b0;
            halt_decoded_q <= 1'b0;
        end else begin
            req_pending_q <= read_m1;
            // Word in flight behind an HLT is dropped here
            fetch_valid_q <= req_pending_q && !stop_fetch;
            if (read_m1) begin
                pc_q <= pc_q + word_t'(1);
            end
            if (hlt_now) begin
                halt_decoded_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        fetch_word_q <= data1;
    end

    ////////////////////////////////////////////////////////////
    // Decode

    assign read_reg_a = fetch_word_q[`RS_HI:`RS_LO];
    assign read_reg_b = fetch_word_q[`RT_HI:`RT_LO];

    always_comb begin
        instr.func       = FN_ADD;
        instr.dest       = fetch_word_q[`RD_HI:`RD_LO];
        instr.writes_reg = 1'b0;
        instr.use_imm    = 1'b0;
        instr.operand_a  = read_data_a;
        instr.operand_b  = read_data_b;
        instr.imm_value  = '0;
        case (opcode)
            OP_RTYPE: begin
                case (func_raw)
                    FN_ADD, FN_SUB, FN_AND, FN_ORR, FN_NOT, FN_TCP, FN_SHL, FN_SHR: begin
                        instr.func       = alu_func_e'(func_raw);
                        instr.writes_reg = 1'b1;
                    end
                    FN_WWD, FN_HLT: begin
                        instr.func = alu_func_e'(func_raw);
                    end
                    // Unknown function retires as a no-op
                    default: ;
                endcase
            end
            OP_ADI: begin
                instr.func       = FN_ADD;
                instr.dest       = fetch_word_q[`RT_HI:`RT_LO];
                instr.writes_reg = 1'b1;
                instr.use_imm    = 1'b1;
                instr.imm_value  = {{(`WORD_SIZE-`IMM_W){imm_raw[`IMM_W-1]}}, imm_raw};
            end
            OP_ORI: begin
                instr.func       = FN_ORR;
                instr.dest       = fetch_word_q[`RT_HI:`RT_LO];
                instr.writes_reg = 1'b1;
                instr.use_imm    = 1'b1;
                instr.imm_value  = {{(`WORD_SIZE-`IMM_W){1'b0}}, imm_raw};
            end
            OP_LHI: begin
                instr.func       = FN_LHI;
                instr.dest       = fetch_word_q[`RT_HI:`RT_LO];
                instr.writes_reg = 1'b1;
                instr.use_imm    = 1'b1;
                instr.imm_value  = {imm_raw, {(`WORD_SIZE-`IMM_W){1'b0}}};
            end
            default: ;
        endcase
    end

    assign dec.valid = fetch_valid_q;
    assign dec.instr = instr;

    // Execute halts only on an HLT decoded here, and the port is quiet by then
    property p_quiet_after_hlt;
        @(posedge clk) disable iff (reset_n)
            dec.halt_seen |-> (halt_decoded_q && !read_m1 && !fetch_valid_q);
    endproperty
    a_quiet_after_hlt: assert property (p_quiet_after_hlt)
        else $error("instruction fetch active after HLT");

endmodule

//--- register_file.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module register_file (
    input  logic               clk,
    input  logic               reset_n,
    input  cpu_pkg::reg_addr_t read_reg_a,
    input  cpu_pkg::reg_addr_t read_reg_b,
    output cpu_pkg::word_t     read_data_a,
    output cpu_pkg::word_t     read_data_b,
    input  logic               wb_en,
    input  cpu_pkg::reg_addr_t wb_reg,
    input  cpu_pkg::word_t     wb_data
);
    import cpu_pkg::*;

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_reg] <= wb_data;
        end
    end

    // Write-through, so decode sees the result of the instruction in execute
    function automatic word_t read_port(reg_addr_t addr);
        if (wb_en && (wb_reg == addr)) begin
            return wb_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        read_data_a = read_port(read_reg_a);
        read_data_b = read_port(read_reg_b);
    end

endmodule

//--- decoded_if.sv
`timescale 1ns/1ps

interface decoded_if;
    import cpu_pkg::*;

    logic     valid;
    decoded_t instr;
    // Driven back from execute once HLT has retired
    logic     halt_seen;

    modport producer (
        output valid,
        output instr,
        input  halt_seen
    );

    modport buffer_in (
        input  valid,
        input  instr,
        output halt_seen
    );

    modport buffer_out (
        output valid,
        output instr,
        input  halt_seen
    );

    modport consumer (
        input  valid,
        input  instr,
        output halt_seen
    );

endinterface

//--- cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`WORD_SIZE-1:0]  word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Only the opcodes this core executes
    typedef enum logic [`OPCODE_HI-`OPCODE_LO:0] {
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_RTYPE = 4'd15
    } opcode_e;

    // R-type function codes, FN_LHI is internal only
    typedef enum logic [`FUNC_HI-`FUNC_LO:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_LHI = 6'd8,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } alu_func_e;

    typedef struct packed {
        alu_func_e func;
        reg_addr_t dest;
        logic      writes_reg;
        logic      use_imm;
        word_t     operand_a;
        word_t     operand_b;
        word_t     imm_value;
    } decoded_t;

endpackage

//--- cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath and register file sizes
`define WORD_SIZE  16
`define REG_COUNT  4
`define REG_ADDR_W 2
`define IMM_W      8

// Instruction fields
`define OPCODE_HI 15
`define OPCODE_LO 12
`define RS_HI     11
`define RS_LO     10
`define RT_HI     9
`define RT_LO     8
`define RD_HI     7
`define RD_LO     6
`define FUNC_HI   5
`define FUNC_LO   0

`endif
